// File: vlog.f
hw/bus_pkg.sv
hw/mem_bus_if.sv
hw/cmd_launcher.sv
hw/bus_decoder.sv
hw/mem_slave.sv
hw/uart_tx.sv
hw/uart_rx.sv
hw/bridge_slave.sv
hw/bridge_master.sv
hw/dual_bus_top.sv
dv/tb_top.sv

// File: dv/tb_top.sv
`timescale 1ns/1ps
`default_nettype none

module tb_top;

    localparam int reset_cycles   = 8;
    localparam int n_random       = 40;
    // Directed transactions are 2 local, 2 remote, 4 unmapped and 2 around the ignored edge
    localparam int n_txn          = 10 + n_random;
    localparam int timeout_cycles = n_txn * 40 * bus_pkg::clocks_per_bit + reset_cycles;

    logic               clk;
    logic               rstn;
    logic               start;
    logic               mode;
    bus_pkg::data_t     wr_data;
    bus_pkg::dev_t      device;
    bus_pkg::mem_addr_t mem_addr;
    logic               busy;
    bus_pkg::data_t     rd_data;
    bus_pkg::data_t     mem_1;
    bus_pkg::data_t     mem_2;

    // Reference model state
    bus_pkg::data_t model_mem_a [bus_pkg::mem_depth];
    bus_pkg::data_t model_mem_b [bus_pkg::mem_depth];
    bus_pkg::data_t model_dbg_a;
    bus_pkg::data_t model_dbg_b;
    bus_pkg::data_t exp_rd;

    int   cycle_cnt = 0;
    event txn_done;

    dual_bus_top dut_i (
        .clk      (clk),
        .rstn     (rstn),
        .start    (start),
        .mode     (mode),
        .wr_data  (wr_data),
        .device   (device),
        .mem_addr (mem_addr),
        .busy     (busy),
        .rd_data  (rd_data),
        .mem_1    (mem_1),
        .mem_2    (mem_2)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // ====================
    // Error handling
    // ====================
    task automatic report_error(input string msg);
        $display("%s", msg);
        $display("SIMULATION FAILED");
        $fatal(1, "Run stopped at first error");
    endtask

    task automatic check_data(input string name, input bus_pkg::data_t actual,
                              input bus_pkg::data_t expected);
        if (actual !== expected)
            report_error($sformatf("Mismatch at %0t ns: %s is %02h, expected %02h",
                                   $time, name, actual, expected));
    endtask

    task automatic check_busy(input logic expected);
        if (busy !== expected)
            report_error($sformatf("Mismatch at %0t ns: busy is %b, expected %b",
                                   $time, busy, expected));
    endtask

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= timeout_cycles)
            report_error($sformatf("Timeout: no end of test after %0d cycles", cycle_cnt));
    end

    // ====================
    // Reference model
    // ====================
    // Applies one access to the model and returns the byte a read would see
    function automatic bus_pkg::data_t ref_access(input logic wen, input bus_pkg::dev_t dev,
                                                  input bus_pkg::mem_addr_t addr,
                                                  input bus_pkg::data_t wdata);
        bus_pkg::data_t rd_val;
        rd_val = '0;
        case (dev)
            bus_pkg::dev_bridge: begin
                if (wen) begin
                    model_mem_b[addr] = wdata;
                    model_dbg_b       = wdata;
                end
                rd_val = model_mem_b[addr];
            end
            bus_pkg::dev_local: begin
                if (wen) begin
                    model_mem_a[addr] = wdata;
                    model_dbg_a       = wdata;
                end
                rd_val = model_mem_a[addr];
            end
            default: rd_val = '0;   // unmapped
        endcase
        return rd_val;
    endfunction

    // Compare after every completed transaction
    initial begin
        forever begin
            @(txn_done);
            check_data("rd_data", rd_data, exp_rd);
            check_data("mem_1", mem_1, model_dbg_b);
            check_data("mem_2", mem_2, model_dbg_a);
        end
    end

    // ====================
    // Stimulus helpers
    // ====================
    task automatic wait_busy_level(input logic level);
        while (busy !== level)
            @(negedge clk);
    endtask

    task automatic run_txn(input logic wen, input bus_pkg::dev_t dev,
                           input bus_pkg::mem_addr_t addr, input bus_pkg::data_t wdata);
        bus_pkg::data_t rd_val;
        @(negedge clk);
        mode     = wen;
        device   = dev;
        mem_addr = addr;
        wr_data  = wdata;
        start    = 1'b1;
        wait_busy_level(1'b1);
        wait_busy_level(1'b0);
        start  = 1'b0;
        rd_val = ref_access(wen, dev, addr, wdata);
        if (!wen)
            exp_rd = rd_val;
        -> txn_done;
        // Let start low pass the sync flops before the next edge
        repeat (4) @(negedge clk);
        // A held start level must not launch a second transaction
        check_busy(1'b0);
    endtask

    initial begin
        bus_pkg::data_t rd_val;
        void'($urandom(32'h22db63c2));
        rstn     = 1'b0;
        start    = 1'b0;
        mode     = 1'b0;
        wr_data  = '0;
        device   = '0;
        mem_addr = '0;
        exp_rd   = '0;
        model_dbg_a = '0;
        model_dbg_b = '0;
        foreach (model_mem_a[i]) begin
            model_mem_a[i] = '0;
            model_mem_b[i] = '0;
        end

        repeat (reset_cycles) @(negedge clk);
        rstn = 1'b1;
        @(negedge clk);

        // Idle state after reset
        check_busy(1'b0);
        check_data("rd_data", rd_data, 8'h00);
        check_data("mem_1", mem_1, 8'h00);
        check_data("mem_2", mem_2, 8'h00);

        // Local memory on device 1
        run_txn(1'b1, bus_pkg::dev_local, 6'd5, 8'ha5);
        run_txn(1'b0, bus_pkg::dev_local, 6'd5, 8'h00);

        // Remote memory through the UART bridge
        run_txn(1'b1, bus_pkg::dev_bridge, 6'd5, 8'h3c);
        run_txn(1'b0, bus_pkg::dev_bridge, 6'd5, 8'h00);

        // Unmapped devices
        run_txn(1'b1, 2'd2, 6'd5, 8'hff);
        run_txn(1'b0, 2'd2, 6'd5, 8'h00);
        run_txn(1'b1, 2'd3, 6'd63, 8'h81);
        run_txn(1'b0, 2'd3, 6'd63, 8'h00);

        // Random mix over all devices
        repeat (n_random) begin
            run_txn(1'($urandom_range(0, 1)), bus_pkg::dev_t'($urandom_range(0, 3)),
                    bus_pkg::mem_addr_t'($urandom_range(0, bus_pkg::mem_depth - 1)),
                    bus_pkg::data_t'($urandom));
        end

        // Second start edge in the middle of a remote read
        @(negedge clk);
        mode     = 1'b0;
        device   = bus_pkg::dev_bridge;
        mem_addr = 6'd5;
        wr_data  = '0;
        start    = 1'b1;
        wait_busy_level(1'b1);
        start = 1'b0;
        repeat (4) @(negedge clk);
        mode     = 1'b1;
        device   = bus_pkg::dev_local;
        mem_addr = 6'd9;
        wr_data  = 8'h77;
        start    = 1'b1;
        repeat (4) @(negedge clk);
        check_busy(1'b1);
        start = 1'b0;
        wait_busy_level(1'b0);
        rd_val = ref_access(1'b0, bus_pkg::dev_bridge, 6'd5, 8'h00);
        exp_rd = rd_val;
        -> txn_done;
        repeat (12) @(negedge clk);
        check_busy(1'b0);
        // Address 9 must still hold its old byte
        run_txn(1'b0, bus_pkg::dev_local, 6'd9, 8'h00);

        $display("SIMULATION PASSED");
        $finish;
    end

endmodule

`default_nettype wire

// File: hw/dual_bus_top.sv
`timescale 1ns/1ps
`default_nettype none

module dual_bus_top (
    input  wire                     clk,
    input  wire                     rstn,
    input  wire                     start,
    input  wire                     mode,
    input  wire bus_pkg::data_t     wr_data,
    input  wire bus_pkg::dev_t      device,
    input  wire bus_pkg::mem_addr_t mem_addr,
    output logic                    busy,
    output bus_pkg::data_t          rd_data,
    output bus_pkg::data_t          mem_1,
    output bus_pkg::data_t          mem_2
);

    mem_bus_if bus_a ();
    mem_bus_if bus_a_bridge ();
    mem_bus_if bus_a_mem ();
    mem_bus_if bus_b ();

    wire uart_a_to_b;
    wire uart_b_to_a;

    // ====================
    // Bus A
    // ====================
    cmd_launcher launcher_i (
        .clk      (clk),
        .rstn     (rstn),
        .start    (start),
        .mode     (mode),
        .wr_data  (wr_data),
        .device   (device),
        .mem_addr (mem_addr),
        .bus      (bus_a),
        .busy     (busy),
        .rd_data  (rd_data)
    );

    bus_decoder decoder_i (
        .up        (bus_a),
        .bridge    (bus_a_bridge),
        .local_mem (bus_a_mem)
    );

    mem_slave mem_a_i (
        .clk        (clk),
        .rstn       (rstn),
        .bus        (bus_a_mem),
        .debug_byte (mem_2)
    );

    bridge_slave bridge_slave_i (
        .clk     (clk),
        .rstn    (rstn),
        .bus     (bus_a_bridge),
        .rx_line (uart_b_to_a),
        .tx_line (uart_a_to_b)
    );

    // ====================
    // Bus B
    // ====================
    bridge_master bridge_master_i (
        .clk     (clk),
        .rstn    (rstn),
        .bus     (bus_b),
        .rx_line (uart_a_to_b),
        .tx_line (uart_b_to_a)
    );

    mem_slave mem_b_i (
        .clk        (clk),
        .rstn       (rstn),
        .bus        (bus_b),
        .debug_byte (mem_1)
    );

endmodule

`default_nettype wire

// File: hw/bridge_master.sv
`timescale 1ns/1ps
`default_nettype none

module bridge_master (
    input  wire       clk,
    input  wire       rstn,
    mem_bus_if.master bus,
    input  wire       rx_line,
    output logic      tx_line
);

    bus_pkg::req_frame_t req_frame;
    bus_pkg::req_frame_t req_q;
    bus_pkg::rsp_frame_t rsp_q;
    logic                req_got;
    logic                active;
    logic                send;
    logic                rsp_busy;
    logic                tx_busy;

    // Frames arriving during a transaction or a response are dropped
    always_ff @(posedge clk) begin
        if (!rstn) begin
            active   <= 1'b0;
            send     <= 1'b0;
            rsp_busy <= 1'b0;
        end else begin
            send <= 1'b0;
            if (active) begin
                if (bus.done) begin
                    active   <= 1'b0;
                    send     <= 1'b1;
                    rsp_busy <= 1'b1;
                end
            end else if (rsp_busy) begin
                // tx busy only shows up the cycle after send
                if (!send && !tx_busy)
                    rsp_busy <= 1'b0;
            end else if (req_got) begin
                active <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!active && !rsp_busy && req_got)
            req_q <= req_frame;
        if (active && bus.done)
            rsp_q <= bus.rdata;
    end

    assign bus.valid = active;
    assign bus.wen   = req_q.wen;
    assign bus.addr  = '{dev: bus_pkg::dev_local, mem: req_q.addr};
    assign bus.wdata = req_q.wdata;

    uart_rx #(
        .payload_t (bus_pkg::req_frame_t)
    ) req_rx_i (
        .clk     (clk),
        .rstn    (rstn),
        .line    (rx_line),
        .got     (req_got),
        .payload (req_frame)
    );

    uart_tx #(
        .payload_t (bus_pkg::rsp_frame_t)
    ) rsp_tx_i (
        .clk     (clk),
        .rstn    (rstn),
        .send    (send),
        .payload (rsp_q),
        .line    (tx_line),
        .busy    (tx_busy)
    );

endmodule

`default_nettype wire

// File: hw/bridge_slave.sv
`timescale 1ns/1ps
`default_nettype none

module bridge_slave (
    input  wire      clk,
    input  wire      rstn,
    mem_bus_if.slave bus,
    input  wire      rx_line,
    output logic     tx_line
);

    bus_pkg::req_frame_t req_frame;
    bus_pkg::rsp_frame_t rsp_frame;
    logic                send;
    logic                tx_busy;
    logic                rsp_got;
    logic                pending;

    assign req_frame = '{wen: bus.wen, addr: bus.addr.mem, wdata: bus.wdata};

    // Launch once per request, then wait for the response frame
    always_ff @(posedge clk) begin
        if (!rstn) begin
            send     <= 1'b0;
            pending  <= 1'b0;
            bus.done <= 1'b0;
        end else begin
            send     <= 1'b0;
            bus.done <= 1'b0;
            if (!pending) begin
                if (bus.valid && !bus.done && !tx_busy) begin
                    send    <= 1'b1;
                    pending <= 1'b1;
                end
            end else if (rsp_got) begin
                pending  <= 1'b0;
                bus.done <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (pending && rsp_got)
            bus.rdata <= rsp_frame;
    end

    // Request is held on the bus while the frame goes out
    uart_tx #(
        .payload_t (bus_pkg::req_frame_t)
    ) req_tx_i (
        .clk     (clk),
        .rstn    (rstn),
        .send    (send),
        .payload (req_frame),
        .line    (tx_line),
        .busy    (tx_busy)
    );

    uart_rx #(
        .payload_t (bus_pkg::rsp_frame_t)
    ) rsp_rx_i (
        .clk     (clk),
        .rstn    (rstn),
        .line    (rx_line),
        .got     (rsp_got),
        .payload (rsp_frame)
    );

endmodule

`default_nettype wire

// File: hw/uart_rx.sv
`timescale 1ns/1ps
`default_nettype none

module uart_rx #(
    parameter type payload_t = bus_pkg::data_t
) (
    input  wire      clk,
    input  wire      rstn,
    input  wire      line,
    output logic     got,
    output payload_t payload
);

    localparam int pay_w  = $bits(payload_t);
    localparam int tick_w = $clog2(bus_pkg::clocks_per_bit);
    localparam int idx_w  = $clog2(pay_w + 2);

    logic              active;
    logic [tick_w-1:0] tick_cnt;
    logic [idx_w-1:0]  bit_idx;
    logic [pay_w-1:0]  shreg;
    logic              sample;

    assign sample = active && (tick_cnt == tick_w'(bus_pkg::clocks_per_bit - 1));

    // ====================
    // Bit timing
    // ====================
    always_ff @(posedge clk) begin
        if (!rstn) begin
            active   <= 1'b0;
            got      <= 1'b0;
            tick_cnt <= '0;
            bit_idx  <= '0;
        end else begin
            got <= 1'b0;
            if (!active) begin
                bit_idx <= '0;
                if (!line) begin
                    // Preload so the first sample hits mid start bit
                    active   <= 1'b1;
                    tick_cnt <= tick_w'(bus_pkg::clocks_per_bit - bus_pkg::clocks_per_bit / 2);
                end
            end else if (sample) begin
                tick_cnt <= '0;
                bit_idx  <= bit_idx + 1'b1;
                if (bit_idx == '0 && line) begin
                    active <= 1'b0;   // glitch, not a real start bit
                end else if (bit_idx == idx_w'(pay_w + 1)) begin
                    active <= 1'b0;
                    got    <= 1'b1;
                end
            end else begin
                tick_cnt <= tick_cnt + 1'b1;
            end
        end
    end

    // Data bits arrive LSB first
    always_ff @(posedge clk) begin
        if (sample && bit_idx != '0 && bit_idx <= idx_w'(pay_w))
            shreg <= {line, shreg[pay_w-1:1]};
        if (sample && bit_idx == idx_w'(pay_w + 1))
            payload <= payload_t'(shreg);
    end

endmodule

`default_nettype wire

// File: hw/uart_tx.sv
`timescale 1ns/1ps
`default_nettype none

module uart_tx #(
    parameter type payload_t = bus_pkg::data_t
) (
    input  wire      clk,
    input  wire      rstn,
    input  wire      send,
    input  wire payload_t payload,
    output logic     line,
    output logic     busy
);

    localparam int pay_w   = $bits(payload_t);
    localparam int frame_w = pay_w + 2;
    localparam int tick_w  = $clog2(bus_pkg::clocks_per_bit);
    localparam int idx_w   = $clog2(frame_w);

    logic [tick_w-1:0] tick_cnt;
    logic [idx_w-1:0]  bit_idx;
    logic [pay_w:0]    shreg;     // Data bits still to go, then stop
    logic              bit_end;

    assign bit_end = (tick_cnt == tick_w'(bus_pkg::clocks_per_bit - 1));

    always_ff @(posedge clk) begin
        if (!rstn) begin
            line     <= 1'b1;
            busy     <= 1'b0;
            tick_cnt <= '0;
            bit_idx  <= '0;
        end else if (!busy) begin
            tick_cnt <= '0;
            bit_idx  <= '0;
            if (send) begin
                line <= 1'b0;
                busy <= 1'b1;
            end
        end else if (bit_end) begin
            tick_cnt <= '0;
            if (bit_idx == idx_w'(frame_w - 1)) begin
                line <= 1'b1;
                busy <= 1'b0;
            end else begin
                line    <= shreg[0];
                bit_idx <= bit_idx + 1'b1;
            end
        end else begin
            tick_cnt <= tick_cnt + 1'b1;
        end
    end

    // LSB first
    always_ff @(posedge clk) begin
        if (!busy && send)
            shreg <= {1'b1, payload};
        else if (busy && bit_end)
            shreg <= shreg >> 1;
    end

endmodule

`default_nettype wire

// File: hw/mem_slave.sv
`timescale 1ns/1ps
`default_nettype none

module mem_slave (
    input  wire            clk,
    input  wire            rstn,
    mem_bus_if.slave       bus,
    output bus_pkg::data_t debug_byte
);

    bus_pkg::data_t mem [bus_pkg::mem_depth];
    logic           in_prog;
    logic           accept;

    // Device field is ignored, only the memory field indexes
    assign accept = bus.valid && !in_prog;

    always_ff @(posedge clk) begin
        if (!rstn) begin
            bus.done   <= 1'b0;
            in_prog    <= 1'b0;
            debug_byte <= '0;
            mem        <= '{default: '0};
        end else begin
            bus.done <= accept;
            if (accept) begin
                in_prog <= 1'b1;
                if (bus.wen) begin
                    mem[bus.addr.mem] <= bus.wdata;
                    debug_byte        <= bus.wdata;
                end
            end else if (!bus.valid) begin
                in_prog <= 1'b0;
            end
        end
    end

    // Writes return the new byte
    always_ff @(posedge clk) begin
        if (accept)
            bus.rdata <= bus.wen ? bus.wdata : mem[bus.addr.mem];
    end

endmodule

`default_nettype wire

// File: hw/bus_decoder.sv
`timescale 1ns/1ps
`default_nettype none

module bus_decoder (
    mem_bus_if.slave  up,
    mem_bus_if.master bridge,
    mem_bus_if.master local_mem
);

    bus_pkg::dev_t sel;

    assign sel = up.addr.dev;

    // ====================
    // Request fan-out
    // ====================
    assign bridge.valid    = up.valid && (sel == bus_pkg::dev_bridge);
    assign bridge.wen      = up.wen;
    assign bridge.addr     = up.addr;
    assign bridge.wdata    = up.wdata;

    assign local_mem.valid = up.valid && (sel == bus_pkg::dev_local);
    assign local_mem.wen   = up.wen;
    assign local_mem.addr  = up.addr;
    assign local_mem.wdata = up.wdata;

    // ====================
    // Response select
    // ====================
    always_comb begin
        case (sel)
            bus_pkg::dev_bridge: begin
                up.done  = bridge.done;
                up.rdata = bridge.rdata;
            end
            bus_pkg::dev_local: begin
                up.done  = local_mem.done;
                up.rdata = local_mem.rdata;
            end
            default: begin
                // Unmapped, finish right away with zero
                up.done  = up.valid;
                up.rdata = '0;
            end
        endcase
    end

endmodule

`default_nettype wire

// File: hw/cmd_launcher.sv
`timescale 1ns/1ps
`default_nettype none

module cmd_launcher (
    input  wire                     clk,
    input  wire                     rstn,
    input  wire                     start,
    input  wire                     mode,
    input  wire bus_pkg::data_t     wr_data,
    input  wire bus_pkg::dev_t      device,
    input  wire bus_pkg::mem_addr_t mem_addr,
    mem_bus_if.master               bus,
    output logic                    busy,
    output bus_pkg::data_t          rd_data
);

    logic [1:0]         start_sync;
    logic               start_prev;
    logic               start_pulse;
    logic               req_wen;
    bus_pkg::bus_addr_t req_addr;
    bus_pkg::data_t     req_wdata;

    // Two sync flops, then edge detect
    always_ff @(posedge clk) begin
        if (!rstn) begin
            start_sync <= '0;
            start_prev <= 1'b0;
        end else begin
            start_sync <= {start_sync[0], start};
            start_prev <= start_sync[1];
        end
    end

    assign start_pulse = start_sync[1] & ~start_prev;

    // Busy spans the whole transaction, edges during it are dropped
    always_ff @(posedge clk) begin
        if (!rstn) begin
            busy    <= 1'b0;
            rd_data <= '0;
        end else if (busy) begin
            if (bus.done) begin
                busy <= 1'b0;
                if (!req_wen)
                    rd_data <= bus.rdata;
            end
        end else if (start_pulse) begin
            busy <= 1'b1;
        end
    end

    // Mode high means write
    always_ff @(posedge clk) begin
        if (start_pulse && !busy) begin
            req_wen   <= mode;
            req_addr  <= '{dev: device, mem: mem_addr};
            req_wdata <= wr_data;
        end
    end

    assign bus.valid = busy;
    assign bus.wen   = req_wen;
    assign bus.addr  = req_addr;
    assign bus.wdata = req_wdata;

endmodule

`default_nettype wire

// File: hw/mem_bus_if.sv
`timescale 1ns/1ps
`default_nettype none

interface mem_bus_if;

    // Request, held by the master until done
    logic               valid;
    logic               wen;
    bus_pkg::bus_addr_t addr;
    bus_pkg::data_t     wdata;

    // Completion, one-cycle pulse with read data
    logic               done;
    bus_pkg::data_t     rdata;

    modport master (
        output valid,
        output wen,
        output addr,
        output wdata,
        input  done,
        input  rdata
    );

    modport slave (
        input  valid,
        input  wen,
        input  addr,
        input  wdata,
        output done,
        output rdata
    );

endinterface

`default_nettype wire

// File: hw/bus_pkg.sv
`default_nettype none

package bus_pkg;

    // ====================
    // Widths and sizes
    // ====================
    localparam int data_w         = 8;
    localparam int mem_aw         = 6;
    localparam int dev_w          = 2;
    localparam int mem_depth      = 64;

    // UART bit time in clock cycles
    localparam int clocks_per_bit = 5;

    typedef logic [data_w-1:0] data_t;
    typedef logic [mem_aw-1:0] mem_addr_t;
    typedef logic [dev_w-1:0]  dev_t;

    // Device map on bus A
    localparam dev_t dev_bridge = 2'd0;
    localparam dev_t dev_local  = 2'd1;

    typedef struct packed {
        dev_t      dev;
        mem_addr_t mem;
    } bus_addr_t;

    // ====================
    // UART frame payloads
    // ====================
    typedef struct packed {
        logic      wen;
        mem_addr_t addr;
        data_t     wdata;
    } req_frame_t;

    typedef data_t rsp_frame_t;

endpackage

`default_nettype wire
